//--- hdl/fp_div_macros.svh
`ifndef FP_DIV_MACROS_SVH
`define FP_DIV_MACROS_SVH

// binary32 field widths
`define FP_W            32
`define EXP_W           8
`define MANT_W          23

// significand including the hidden one
`define SIG_W           24

// 24 significand bits, guard, round and one more bit for sticky
`define QUOT_W          27

// unbiased exponent limits of normal numbers
`define EXP_BIAS        127
`define EXP_MAX         127
`define EXP_MIN         (-126)

// all ones exponent field marks infinity or NaN
`define EXP_FIELD_MAX   255

// quiet NaN returned for invalid operations
`define QNAN_WORD       32'hffc0_0000

`endif

//--- hdl/fp_div_pkg.sv
`include "fp_div_macros.svh"

package fp_div_pkg;

    // wide enough for a - b plus the normalise and round steps
    typedef logic signed [9:0] fp_exp_t;

    typedef logic [`SIG_W-1:0] fp_sig_t;

    typedef logic [`QUOT_W-1:0] fp_quot_t;

    typedef enum logic [1:0]
    {
        cls_unpack,
        cls_decide,
        cls_wait_result
    } classify_state_e;

    typedef enum logic
    {
        div_idle,
        div_run
    } divider_state_e;

    typedef enum logic [1:0]
    {
        pk_idle,
        pk_normalise,
        pk_round,
        pk_pack
    } pack_state_e;

endpackage

//--- hdl/fp_div_op_if.sv
`include "fp_div_macros.svh"

interface fp_div_op_if import fp_div_pkg::*; ();

    logic              div_start;
    logic              special_valid;
    logic [`FP_W-1:0]  special_res;
    logic              sign;
    fp_exp_t           exp;
    fp_sig_t           a_sig;
    fp_sig_t           b_sig;

    modport src (
        output div_start, special_valid, special_res, sign, exp, a_sig, b_sig
    );

    modport div (
        input div_start, a_sig, b_sig
    );

    // div_start lets the packer latch sign and exponent
    modport pack (
        input div_start, special_valid, special_res, sign, exp
    );

endinterface

//--- hdl/fp_div_quot_if.sv
interface fp_div_quot_if import fp_div_pkg::*; ();

    logic     done;
    fp_quot_t quot;
    logic     rem_nonzero;

    modport src (
        output done, quot, rem_nonzero
    );

    modport sink (
        input done, quot, rem_nonzero
    );

endinterface

//--- hdl/fp_div_classify.sv
`include "fp_div_macros.svh"

module fp_div_classify import fp_div_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [`FP_W-1:0]  div_a,
    input  logic [`FP_W-1:0]  div_b,
    input  logic              res_valid,
    fp_div_op_if.src          op
);

    classify_state_e         state;
    logic                    sample;
    logic [`FP_W-1:0]        a_q;
    logic [`FP_W-1:0]        b_q;
    logic [`EXP_W-1:0]       a_ef;
    logic [`EXP_W-1:0]       b_ef;
    logic [`MANT_W-1:0]      a_fr;
    logic [`MANT_W-1:0]      b_fr;
    logic                    a_nan;
    logic                    b_nan;
    logic                    a_inf;
    logic                    b_inf;
    logic                    a_zero;
    logic                    b_zero;
    logic                    sign_x;
    logic                    is_special;
    logic [`FP_W-1:0]        special_word;
    logic [`FP_W-1:0]        inf_word;
    logic [`FP_W-1:0]        zero_word;

    function automatic fp_exp_t unbias(input logic [`EXP_W-1:0] field);
        return fp_exp_t'({2'b00, field}) - fp_exp_t'(`EXP_BIAS);
    endfunction

    // the res_valid edge doubles as the next unpack
    assign sample = (state == cls_unpack) || (state == cls_wait_result && res_valid);

    assign a_ef = a_q[`FP_W-2:`MANT_W];
    assign b_ef = b_q[`FP_W-2:`MANT_W];
    assign a_fr = a_q[`MANT_W-1:0];
    assign b_fr = b_q[`MANT_W-1:0];

    assign a_nan  = (a_ef == `EXP_W'(`EXP_FIELD_MAX)) && (a_fr != '0);
    assign b_nan  = (b_ef == `EXP_W'(`EXP_FIELD_MAX)) && (b_fr != '0);
    assign a_inf  = (a_ef == `EXP_W'(`EXP_FIELD_MAX)) && (a_fr == '0);
    assign b_inf  = (b_ef == `EXP_W'(`EXP_FIELD_MAX)) && (b_fr == '0);
    // subnormals count as zero
    assign a_zero = (a_ef == '0);
    assign b_zero = (b_ef == '0);

    assign sign_x    = a_q[`FP_W-1] ^ b_q[`FP_W-1];
    assign inf_word  = {sign_x, `EXP_W'(`EXP_FIELD_MAX), `MANT_W'(0)};
    assign zero_word = {sign_x, (`FP_W-1)'(0)};

    // special cases in priority order
    always_comb
    begin
        is_special   = 1'b1;
        special_word = zero_word;
        if (a_nan || b_nan)
            special_word = `QNAN_WORD;
        else if (a_inf && b_inf)
            special_word = `QNAN_WORD;
        else if (a_zero && b_zero)
            special_word = `QNAN_WORD;
        else if (a_inf)
            special_word = inf_word;
        else if (b_inf)
            special_word = zero_word;
        else if (a_zero)
            special_word = zero_word;
        else if (b_zero)
            special_word = inf_word;
        else
            is_special = 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state            <= cls_unpack;
            op.div_start     <= 1'b0;
            op.special_valid <= 1'b0;
        end
        else
        begin
            op.div_start     <= 1'b0;
            op.special_valid <= 1'b0;
            case (state)
                cls_unpack:
                    state <= cls_decide;
                cls_decide:
                begin
                    op.div_start     <= !is_special;
                    op.special_valid <= is_special;
                    state            <= cls_wait_result;
                end
                cls_wait_result:
                    if (res_valid)
                        state <= cls_decide;
                default:
                    state <= cls_unpack;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (sample)
        begin
            a_q <= div_a;
            b_q <= div_b;
        end
        if (state == cls_decide)
        begin
            op.special_res <= special_word;
            op.sign        <= sign_x;
            op.exp         <= unbias(a_ef) - unbias(b_ef);
            op.a_sig       <= {1'b1, a_fr};
            op.b_sig       <= {1'b1, b_fr};
        end
    end

    // a result only comes back for the operation in flight
    a_result_awaited: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> state == cls_wait_result)
        else $error("res_valid arrived while no operation was in flight");

endmodule

//--- hdl/fp_div_mant_divider.sv
`include "fp_div_macros.svh"

module fp_div_mant_divider import fp_div_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    fp_div_op_if.div     op,
    fp_div_quot_if.src   quot
);

    divider_state_e     state;
    logic [4:0]         iter;
    logic               busy;
    logic [`SIG_W:0]    rem_q;
    logic [`SIG_W:0]    rem_cur;
    logic [`SIG_W:0]    diff;
    logic [`SIG_W:0]    rem_next;
    fp_sig_t            div_q;
    fp_sig_t            div_cur;
    logic               q_bit;
    fp_quot_t           quot_q;

    // the start cycle already produces the first quotient bit
    assign busy = (state == div_run) || op.div_start;

    assign rem_cur = (state == div_run) ? rem_q : {1'b0, op.a_sig};
    assign div_cur = (state == div_run) ? div_q : op.b_sig;

    assign q_bit    = rem_cur >= {1'b0, div_cur};
    assign diff     = q_bit ? rem_cur - {1'b0, div_cur} : rem_cur;
    // diff < divisor, so the shift never loses a bit
    assign rem_next = diff << 1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= div_idle;
            iter      <= '0;
            quot.done <= 1'b0;
        end
        else
        begin
            quot.done <= 1'b0;
            case (state)
                div_idle:
                    if (op.div_start)
                    begin
                        state <= div_run;
                        iter  <= 5'd1;
                    end
                div_run:
                begin
                    iter <= iter + 5'd1;
                    if (iter == 5'(`QUOT_W - 1))
                    begin
                        state     <= div_idle;
                        quot.done <= 1'b1;
                    end
                end
                default:
                    state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (busy)
        begin
            rem_q  <= rem_next;
            quot_q <= {quot_q[`QUOT_W-2:0], q_bit};
        end
        if (state == div_idle && op.div_start)
            div_q <= op.b_sig;
    end

    assign quot.quot        = quot_q;
    assign quot.rem_nonzero = (rem_q != '0);

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        op.div_start |-> state != div_run)
        else $error("new division started while the divider is busy");

endmodule

//--- hdl/fp_div_round_pack.sv
`include "fp_div_macros.svh"

module fp_div_round_pack import fp_div_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    fp_div_op_if.pack         op,
    fp_div_quot_if.sink       quot,
    output logic [`FP_W-1:0]  div_res,
    output logic              res_valid
);

    pack_state_e        state;
    logic               sign_q;
    fp_exp_t            exp_q;
    fp_exp_t            exp_biased;
    fp_sig_t            sig_q;
    logic               guard_q;
    logic               round_q;
    logic               sticky_q;
    logic               round_up;
    logic [`SIG_W:0]    sig_inc;
    logic [`FP_W-1:0]   packed_word;

    assign round_up   = guard_q && (round_q || sticky_q || sig_q[0]);
    assign sig_inc    = {1'b0, sig_q} + 1'b1;
    assign exp_biased = exp_q + fp_exp_t'(`EXP_BIAS);

    always_comb
    begin
        if (exp_q > `EXP_MAX)
            packed_word = {sign_q, `EXP_W'(`EXP_FIELD_MAX), `MANT_W'(0)};
        else if (exp_q < `EXP_MIN)
            packed_word = {sign_q, (`FP_W-1)'(0)};
        else
            packed_word = {sign_q, exp_biased[`EXP_W-1:0], sig_q[`MANT_W-1:0]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= pk_idle;
            div_res   <= '0;
            res_valid <= 1'b0;
        end
        else
        begin
            res_valid <= 1'b0;
            case (state)
                pk_idle:
                    if (op.special_valid)
                    begin
                        div_res   <= op.special_res;
                        res_valid <= 1'b1;
                    end
                    else if (op.div_start)
                        state <= pk_normalise;
                // waits here for the divider
                pk_normalise:
                    if (quot.done)
                        state <= pk_round;
                pk_round:
                    state <= pk_pack;
                pk_pack:
                begin
                    div_res   <= packed_word;
                    res_valid <= 1'b1;
                    state     <= pk_idle;
                end
                default:
                    state <= pk_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == pk_idle && op.div_start)
        begin
            sign_q <= op.sign;
            exp_q  <= op.exp;
        end

        // quotient lies in (0.5, 2), so one shift at most
        if (state == pk_normalise && quot.done)
        begin
            if (quot.quot[`QUOT_W-1])
            begin
                sig_q    <= quot.quot[`QUOT_W-1 -: `SIG_W];
                guard_q  <= quot.quot[2];
                round_q  <= quot.quot[1];
                sticky_q <= quot.quot[0] | quot.rem_nonzero;
            end
            else
            begin
                sig_q    <= quot.quot[`QUOT_W-2 -: `SIG_W];
                guard_q  <= quot.quot[1];
                round_q  <= quot.quot[0];
                sticky_q <= quot.rem_nonzero;
                exp_q    <= exp_q - fp_exp_t'(1);
            end
        end

        if (state == pk_round && round_up)
        begin
            if (sig_inc[`SIG_W])
            begin
                // all ones rolled over to 1.0
                sig_q <= sig_inc[`SIG_W:1];
                exp_q <= exp_q + fp_exp_t'(1);
            end
            else
                sig_q <= sig_inc[`SIG_W-1:0];
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> !res_valid)
        else $error("res_valid held for more than one cycle");

endmodule

//--- hdl/fp_div_top.sv
`include "fp_div_macros.svh"

module fp_div_top
(
    input  logic              clk,
    input  logic              rst,
    input  logic [`FP_W-1:0]  div_a,
    input  logic [`FP_W-1:0]  div_b,
    output logic [`FP_W-1:0]  div_res,
    output logic              res_valid
);

    fp_div_op_if   op_bus ();
    fp_div_quot_if quot_bus ();

    fp_div_classify i_fp_div_classify (
        .clk       (clk),
        .rst       (rst),
        .div_a     (div_a),
        .div_b     (div_b),
        .res_valid (res_valid),
        .op        (op_bus.src)
    );

    fp_div_mant_divider i_fp_div_mant_divider (
        .clk  (clk),
        .rst  (rst),
        .op   (op_bus.div),
        .quot (quot_bus.src)
    );

    fp_div_round_pack i_fp_div_round_pack (
        .clk       (clk),
        .rst       (rst),
        .op        (op_bus.pack),
        .quot      (quot_bus.sink),
        .div_res   (div_res),
        .res_valid (res_valid)
    );

endmodule

//--- bench/fp_div_tb.sv
`include "fp_div_macros.svh"

module fp_div_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rst;
    logic [`FP_W-1:0]  div_a;
    logic [`FP_W-1:0]  div_b;
    logic [`FP_W-1:0]  div_res;
    logic              res_valid;
    logic [31:0]       lfsr_state;
    logic [`FP_W-1:0]  last_res;
    logic [`FP_W-1:0]  op_a;
    logic [`FP_W-1:0]  op_b;

    fp_div_top i_fp_div_top (
        .clk       (clk),
        .rst       (rst),
        .div_a     (div_a),
        .div_b     (div_b),
        .div_res   (div_res),
        .res_valid (res_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    // normal number with exponent field in [lo, hi]
    function automatic logic [31:0] rand_normal(input int lo, input int hi);
        logic [31:0] w;
        int          e;
        w = rand_bits(32);
        e = lo + int'(rand_bits(8)) % (hi - lo + 1);
        w[30:23] = 8'(e);
        return w;
    endfunction

    function automatic logic [31:0] rand_special();
        logic [31:0] w;
        case (rand_bits(3))
            0:       w = 32'h7fc0_0000;
            1:       w = 32'h7f80_0001;
            2:       w = 32'h7fff_ffff;
            3, 4:    w = 32'h7f80_0000;
            5:       w = 32'h0000_0000;
            // subnormals are read as zero
            6:       w = 32'h0000_0001;
            default: w = 32'h007f_ffff;
        endcase
        w[31] = rand_bits(1) != 0;
        return w;
    endfunction

    // kind 0 normal, 1 special, 2 overflow side, 3 underflow side
    task automatic pick_operands(input int kind, output logic [31:0] a, output logic [31:0] b);
        logic [31:0] sel;
        case (kind)
            0:
            begin
                a = rand_normal(119, 135);
                b = rand_normal(119, 135);
            end
            1:
            begin
                sel = rand_bits(2);
                a = (sel == 2) ? rand_normal(100, 150) : rand_special();
                b = (sel == 1) ? rand_normal(100, 150) : rand_special();
            end
            2:
            begin
                a = rand_normal(200, 254);
                b = rand_normal(60, 80);
            end
            default:
            begin
                a = rand_normal(1, 60);
                b = rand_normal(180, 200);
            end
        endcase
    endtask

    function automatic logic [31:0] model_div(input logic [31:0] a, input logic [31:0] b);
        logic        sign;
        logic [31:0] inf_w;
        logic [31:0] zero_w;
        int          ea;
        int          eb;
        int          e;
        logic [63:0] num;
        logic [63:0] den;
        logic [63:0] q;
        logic        rem_nz;
        logic        g;
        logic        r;
        logic        st;
        logic [24:0] m;
        sign   = a[31] ^ b[31];
        ea     = int'(a[30:23]);
        eb     = int'(b[30:23]);
        inf_w  = {sign, 8'hff, 23'd0};
        zero_w = {sign, 31'd0};
        if ((ea == 255 && a[22:0] != 0) || (eb == 255 && b[22:0] != 0))
            return `QNAN_WORD;
        if (ea == 255 && eb == 255)
            return `QNAN_WORD;
        if (ea == 0 && eb == 0)
            return `QNAN_WORD;
        if (ea == 255)
            return inf_w;
        if (eb == 255 || ea == 0)
            return zero_w;
        if (eb == 0)
            return inf_w;
        num    = {40'd0, 1'b1, a[22:0]} << 26;
        den    = {40'd0, 1'b1, b[22:0]};
        q      = num / den;
        rem_nz = (num % den) != 0;
        e      = ea - eb;
        if (q[26])
        begin
            m  = {1'b0, q[26:3]};
            g  = q[2];
            r  = q[1];
            st = q[0] | rem_nz;
        end
        else
        begin
            m  = {1'b0, q[25:2]};
            g  = q[1];
            r  = q[0];
            st = rem_nz;
            e  = e - 1;
        end
        // nearest even
        if (g && (r || st || m[0]))
            m = m + 25'd1;
        if (m[24])
        begin
            m = m >> 1;
            e = e + 1;
        end
        if (e > 127)
            return inf_w;
        if (e < -126)
            return zero_w;
        return {sign, 8'(e + 127), m[22:0]};
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected)
        begin
            $display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, got, expected);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // called 1 ns after an edge, operands are taken on the next edge
    task automatic run_op(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] expected;
        logic        special;
        logic        got;
        int          cycles;
        expected = model_div(a, b);
        special  = (a[30:23] == 8'h00) || (a[30:23] == 8'hff)
                || (b[30:23] == 8'h00) || (b[30:23] == 8'hff);
        div_a    = a;
        div_b    = b;
        got      = 1'b0;
        cycles   = 0;
        while (!got)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (res_valid)
                got = 1'b1;
            else
            begin
                check_equal(div_res, last_res, "div_res changed without res_valid");
                if (cycles >= 100)
                begin
                    $display("timeout: no result arrived within 100 cycles for %h / %h", a, b);
                    $display("RESULT: FAIL");
                    $fatal(1);
                end
            end
        end
        check_equal(32'(cycles), special ? 32'd3 : 32'd32,
                    $sformatf("cycles to res_valid for %h / %h", a, b));
        check_equal(div_res, expected, $sformatf("quotient of %h / %h", a, b));
        last_res = div_res;
    endtask

    initial
    begin
        lfsr_state = 32'd96363;
        rst        = 1'b1;
        div_a      = '0;
        div_b      = '0;
        last_res   = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_equal(32'(res_valid), 32'd0, "res_valid after reset");
        check_equal(div_res, 32'd0, "div_res after reset");

        run_op(32'h3f80_0000, 32'h4040_0000);
        run_op(32'h4000_0000, 32'h4040_0000);
        run_op(32'h3fff_ffff, 32'h3f80_0000);
        run_op(32'h3f80_0000, 32'h3fff_ffff);
        run_op(32'hc0a0_0000, 32'h40a0_0000);
        run_op(32'h7f7f_ffff, 32'h3f7f_ffff);

        for (int k = 0; k < 4; k++)
        begin
            for (int i = 0; i < 100; i++)
            begin
                pick_operands(k, op_a, op_b);
                run_op(op_a, op_b);
            end
        end

        // back to back mix of every kind
        for (int i = 0; i < 400; i++)
        begin
            pick_operands(int'(rand_bits(2)), op_a, op_b);
            run_op(op_a, op_b);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- all.f
+incdir+hdl
hdl/fp_div_pkg.sv
hdl/fp_div_op_if.sv
hdl/fp_div_quot_if.sv
hdl/fp_div_classify.sv
hdl/fp_div_mant_divider.sv
hdl/fp_div_round_pack.sv
hdl/fp_div_top.sv
bench/fp_div_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fp_div_tb -f all.f -o fp_div_sim \
    && ./obj_dir/fp_div_sim | tee sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
